// File: neoVideoOut.f
verilog/colourPkg.sv
verilog/rasterPkg.sv
verilog/paletteRam.sv
verilog/pixelTiming.sv
verilog/colourConvert.sv
verilog/neoVideoOut.sv
tests/neoVideoOutTb.sv

// File: tests/paletteInput.txt
// kind_bank_index_word_flags_colour, kind 1 = palette write, 2 = pixel
// flags bits: shadow, video enable, hblank in, vertical display; colour RRGGBB
1_0_000_7FFF_0_000000
1_0_001_4F00_0_000000
1_0_002_20F0_0_000000
1_0_003_100F_0_000000
1_0_004_7000_0_000000
1_0_005_0800_0_000000
1_0_010_2A5C_0_000000
1_1_010_0800_0_000000
1_0_011_FFFF_0_000000
1_1_011_7000_0_000000
1_0_012_8000_0_000000
1_0_013_F000_0_000000
1_0_014_8F00_0_000000
1_0_015_AA5C_0_000000
// Plain colours, low bits only, both banks
2_0_000_0000_5_FFFFFF
2_0_001_0000_5_FF0000
2_0_002_0000_5_00FF00
2_0_003_0000_5_0000FF
2_0_004_0000_5_080808
2_0_005_0000_5_840000
2_0_010_0000_5_A55AC6
2_1_010_0000_5_840000
2_1_011_0000_5_080808
// Dark step with clamp
2_0_011_0000_5_FBFBFB
2_0_012_0000_5_000000
2_0_013_0000_5_040404
2_0_014_0000_5_F30000
2_0_015_0000_5_A156C2
// Shadow
2_0_000_0000_D_7F7F7F
2_0_010_0000_D_522D63
2_0_011_0000_D_7D7D7D
// Video disabled
2_0_000_0000_1_000000
2_0_015_0000_9_000000
// Blanking inputs
2_0_000_0000_7_FFFFFF
2_0_001_0000_4_FF0000
2_0_002_0000_6_00FF00
2_0_003_0000_5_0000FF
// Rewrite the displayed index
1_0_020_4F00_0_000000
2_0_020_0000_5_FF0000
1_0_020_100F_0_000000
2_0_020_0000_5_0000FF
1_0_020_20F0_0_000000
2_0_020_0000_5_00FF00

// File: tests/neoVideoOutTb.sv
// Testbench for the colour output stage, run from the project root.
// Records come from tests/paletteInput.txt, one 64-bit hex value per line.
// Blanking is predicted from the raster inputs seen at each pixel enable.
`timescale 1ns/1ps
`default_nettype none

module neoVideoOutTb;

	localparam int maxRecords = 64;
	localparam int kindWrite = 1;
	localparam int kindPixel = 2;
	localparam int pixelPeriod = 8;

	logic CLK_48M;
	logic nRESET;
	colourPkg::palWrite palWr;
	logic palBank;
	logic [colourPkg::palAddrWidth-1:0] pixIndex;
	rasterPkg::rasterCtl raster;
	colourPkg::rgbPixel pixel;
	logic hBlank;
	logic vBlank;
	logic cePixel;

	// Kind, bank, index, word, flags, colour from the top down
	logic [63:0] records [0:maxRecords-1];
	int recordCount;
	int cycleCount = 0;
	int cycleLimit = 0;

	// Blanking prediction and pixel enable spacing
	logic hDelay [$];
	logic expHBlank = 1'b0;
	logic expVBlank = 1'b0;
	int clocksSincePulse = 0;
	int pulseCount = 0;

	neoVideoOut neoVideoOut_inst (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.palWr(palWr),
		.palBank(palBank),
		.pixIndex(pixIndex),
		.raster(raster),
		.pixel(pixel),
		.hBlank(hBlank),
		.vBlank(vBlank),
		.cePixel(cePixel)
	);

	initial begin
		CLK_48M = 1'b0;
		forever #20 CLK_48M = ~CLK_48M;
	end

	task automatic reportError(input string msg);
		$display("** Error at time %0t: %s", $time, msg);
		$display("TB FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	// ==================================================
	// Timeout
	// ==================================================
	always @(posedge CLK_48M) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount > cycleLimit) begin
			$display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
			$display("TB FAILED");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	// ==================================================
	// Pixel enable and blanking monitor
	// ==================================================
	always @(posedge CLK_48M) begin
		if (nRESET) begin
			clocksSincePulse++;
			assert (hBlank == expHBlank && vBlank == expVBlank) else
				reportError($sformatf("blanks h=%b v=%b, expected h=%b v=%b",
					hBlank, vBlank, expHBlank, expVBlank));
			// Black until the first pixel enable
			if (pulseCount == 0) begin
				assert (pixel == '0) else
					reportError($sformatf("pixel %h after reset, expected 0", pixel));
			end
			if (cePixel) begin
				assert (clocksSincePulse == pixelPeriod) else
					reportError($sformatf("pixel enable after %0d clocks, expected %0d",
						clocksSincePulse, pixelPeriod));
				clocksSincePulse = 0;
				pulseCount++;
				hDelay.push_back(raster.hBlankIn);
				if (hDelay.size() > 2) begin
					void'(hDelay.pop_front());
				end
				expHBlank = (hDelay.size() == 2) ? hDelay[0] : 1'b0;
				expVBlank = ~raster.vDisplay;
			end else begin
				assert (clocksSincePulse < pixelPeriod) else
					reportError("pixel enable missing after a full pixel period");
			end
		end
	end

	// ==================================================
	// Stimulus tasks
	// ==================================================
	// Returns on a clock edge where the pixel enable is high
	task automatic waitPulse();
		@(posedge CLK_48M);
		while (!cePixel) begin
			@(posedge CLK_48M);
		end
	endtask

	task automatic writeWord(input logic bank, input logic [11:0] addr, input logic [15:0] data);
		@(posedge CLK_48M);
		palWr <= {1'b1, bank, addr, data};
		@(posedge CLK_48M);
		palWr <= '0;
	endtask

	// Flags are shadow, video enable, horizontal blank, vertical display
	task automatic showPixel(input logic bank, input logic [11:0] index,
		input logic [3:0] flags, input logic [23:0] expected);
		waitPulse();
		palBank <= bank;
		pixIndex <= index;
		raster.shadow <= flags[3];
		raster.videoEn <= flags[2];
		raster.hBlankIn <= flags[1];
		raster.vDisplay <= flags[0];
		waitPulse();
		@(posedge CLK_48M);
		assert (pixel == expected) else
			reportError($sformatf("pixel %h at bank %0d index %h, expected %h",
				pixel, bank, index, expected));
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		logic [63:0] rec;
		nRESET = 1'b0;
		palWr = '0;
		palBank = 1'b0;
		pixIndex = '0;
		raster.hBlankIn = 1'b0;
		raster.vDisplay = 1'b1;
		raster.shadow = 1'b0;
		raster.videoEn = 1'b0;
		for (int i = 0; i < maxRecords; i++) begin
			records[i] = '0;
		end
		$readmemh("tests/paletteInput.txt", records);
		recordCount = 0;
		while (recordCount < maxRecords && records[recordCount][63:60] != 4'h0) begin
			recordCount++;
		end
		if (recordCount == 0) begin
			$display("No stimulus records could be read from tests/paletteInput.txt");
			$display("TB FAILED");
			$fatal(1, "Missing stimulus");
		end
		cycleLimit = 16 * recordCount + 100;

		repeat (5) @(posedge CLK_48M);
		nRESET <= 1'b1;

		for (int i = 0; i < recordCount; i++) begin
			rec = records[i];
			if (rec[63:60] == kindWrite) begin
				writeWord(rec[56], rec[55:44], rec[43:28]);
			end else if (rec[63:60] == kindPixel) begin
				showPixel(rec[56], rec[55:44], rec[27:24], rec[23:0]);
			end else begin
				reportError($sformatf("record %0d has unknown kind %h", i, rec[63:60]));
			end
		end

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/neoVideoOut.sv
// Colour output stage: palette RAM, pixel timing and colour conversion.
// Pixel index and bank must be stable in the clock before a pixel enable;
// the RGB output then changes on that enable and holds for 8 clocks.
// Nothing stalls, there is no back-pressure on writes or pixels.
`timescale 1ns/1ps
`default_nettype none

module neoVideoOut (
	input wire logic CLK_48M,
	input wire logic nRESET,
	input wire colourPkg::palWrite palWr,
	input wire logic palBank,
	input wire logic [colourPkg::palAddrWidth-1:0] pixIndex,
	input wire rasterPkg::rasterCtl raster,
	output colourPkg::rgbPixel pixel,
	output logic hBlank,
	output logic vBlank,
	output logic cePixel
);

	// Registered palette word for the current pixel
	colourPkg::palWord palData;

	paletteRam paletteRam_inst (
		.CLK_48M(CLK_48M),
		.wr(palWr),
		.bank(palBank),
		.index(pixIndex),
		.word(palData)
	);

	pixelTiming pixelTiming_inst (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.raster(raster),
		.cePixel(cePixel),
		.hBlank(hBlank),
		.vBlank(vBlank)
	);

	// Takes the word on the pixel enable, one clock behind the index
	colourConvert colourConvert_inst (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET),
		.cePixel(cePixel),
		.word(palData),
		.raster(raster),
		.pixel(pixel)
	);

endmodule

`default_nettype wire

// File: verilog/colourConvert.sv
// Expands a palette word into registered 8-bit RGB.
// The word must already reflect the index of the previous clock; the
// result is taken on each pixel enable. Dark removes one 6-bit step,
// clamped at zero. Shadow halves, video enable low forces black.
`timescale 1ns/1ps
`default_nettype none

module colourConvert (
	input wire logic CLK_48M,
	input wire logic nRESET,
	input wire logic cePixel,
	input wire colourPkg::palWord word,
	input wire rasterPkg::rasterCtl raster,
	output colourPkg::rgbPixel pixel
);

	colourPkg::rgbPixel next;

	// 6-bit step is field, low bit, then the field's top bit again
	function automatic logic [colourPkg::chanWidth-1:0] expand(
		input logic [colourPkg::fieldWidth-1:0] field,
		input logic low,
		input logic dark,
		input logic shadow
	);
		logic [colourPkg::stepWidth:0] step;
		logic [colourPkg::chanWidth-1:0] full;
		step = {1'b0, field, low, field[colourPkg::fieldWidth-1]} - dark;
		// Borrow out of the top means the step went below zero
		if (step[colourPkg::stepWidth]) begin
			full = '0;
		end else begin
			full = {step[colourPkg::stepWidth-1:0], step[4:3]};
		end
		if (shadow) begin
			expand = {1'b0, full[colourPkg::chanWidth-1:1]};
		end else begin
			expand = full;
		end
	endfunction

	// ==================================================
	// Channel decode
	// ==================================================
	always_comb begin
		next.red = expand(word.colour.red, word.colour.redLow,
			word.colour.dark, raster.shadow);
		next.green = expand(word.colour.green, word.colour.greenLow,
			word.colour.dark, raster.shadow);
		next.blue = expand(word.colour.blue, word.colour.blueLow,
			word.colour.dark, raster.shadow);
	end

	// ==================================================
	// Output register
	// ==================================================
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			pixel <= '0;
		end else if (cePixel) begin
			// Screen blackout
			if (!raster.videoEn) begin
				pixel <= '0;
			end else begin
				pixel <= next;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/pixelTiming.sv
// Pixel clock enable and blanking delays for the colour output stage.
// cePixel is a one-clock pulse every 8 master clocks, first on the 8th
// clock after reset. hBlank lags its input by two pixel enables and
// vBlank lags the inverted vertical input by one.
`timescale 1ns/1ps
`default_nettype none

module pixelTiming (
	input wire logic CLK_48M,
	input wire logic nRESET,
	input wire rasterPkg::rasterCtl raster,
	output logic cePixel,
	output logic hBlank,
	output logic vBlank
);

	logic [rasterPkg::pixelCountWidth-1:0] count;
	logic hStage;

	// ==================================================
	// Pixel enable divider
	// ==================================================
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			count <= '0;
		end else if (cePixel) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// Last clock of the pixel period
	assign cePixel = (count == rasterPkg::pixelDivide - 1);

	// ==================================================
	// Blanking delay lines
	// ==================================================
	// Horizontal blank goes through two stages to match the
	// palette read plus the colour register
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			hStage <= 1'b0;
			hBlank <= 1'b0;
		end else if (cePixel) begin
			hStage <= raster.hBlankIn;
			hBlank <= hStage;
		end
	end

	// Vertical input is active low, one stage only
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			vBlank <= 1'b0;
		end else if (cePixel) begin
			vBlank <= ~raster.vDisplay;
		end
	end

endmodule

`default_nettype wire

// File: verilog/paletteRam.sv
// Two-bank palette memory with a CPU write port and a pixel read port.
// The read is registered every clock, so the data lags the address by one.
// A read of the address written on the same edge returns the old word.
`timescale 1ns/1ps
`default_nettype none

module paletteRam (
	input wire logic CLK_48M,
	input wire colourPkg::palWrite wr,
	input wire logic bank,
	input wire logic [colourPkg::palAddrWidth-1:0] index,
	output colourPkg::palWord word
);

	// Bank bit sits on top of the index
	logic [15:0] mem [0:colourPkg::palBanks*(2**colourPkg::palAddrWidth)-1];

	// ==================================================
	// CPU write port
	// ==================================================
	always_ff @(posedge CLK_48M) begin
		if (wr.strobe) begin
			mem[{wr.bank, wr.addr}] <= wr.data.raw;
		end
	end

	// ==================================================
	// Pixel read port
	// ==================================================
	// Read before write on a shared address
	always_ff @(posedge CLK_48M) begin
		word.raw <= mem[{bank, index}];
	end

endmodule

`default_nettype wire

// File: verilog/rasterPkg.sv
// Pixel rate and raster control for the colour output stage.
// The pixel rate is a fixed 48 MHz / 8 = 6 MHz.
`default_nettype none

package rasterPkg;

	// Master clocks per pixel
	localparam int pixelDivide = 8;
	localparam int pixelCountWidth = $clog2(pixelDivide);

	// ==================================================
	// Raster control levels
	// ==================================================
	// All are levels held for at least one pixel period
	typedef struct packed {
		// High while the horizontal blank is active
		logic hBlankIn;
		// Low during vertical blank
		logic vDisplay;
		// Halves every channel
		logic shadow;
		// Low blacks out the picture
		logic videoEn;
	} rasterCtl;

endpackage

`default_nettype wire

// File: verilog/colourPkg.sv
// Palette word layout and RGB output types for the colour output stage.
// The 16-bit word format is fixed by the console hardware and cannot be
// resized. Channels come out as 8 bits, widened from a 6-bit step.
`default_nettype none

package colourPkg;

	// ==================================================
	// Sizes
	// ==================================================
	localparam int palAddrWidth = 12;
	localparam int palBanks = 2;

	// 4-bit field, 6-bit step after the low bit, 8-bit output
	localparam int fieldWidth = 4;
	localparam int stepWidth = 6;
	localparam int chanWidth = 8;

	// ==================================================
	// Palette word
	// ==================================================
	// Bit 15 is dark, 14..12 hold the low bits for R, G and B
	typedef struct packed {
		logic dark;
		logic redLow;
		logic greenLow;
		logic blueLow;
		logic [fieldWidth-1:0] red;
		logic [fieldWidth-1:0] green;
		logic [fieldWidth-1:0] blue;
	} palColour;

	// The CPU sees a plain word, the video side sees the colour fields
	typedef union packed {
		logic [15:0] raw;
		palColour colour;
	} palWord;

	// One-cycle write strobe with bank, index and data
	typedef struct packed {
		logic strobe;
		logic bank;
		logic [palAddrWidth-1:0] addr;
		palWord data;
	} palWrite;

	typedef struct packed {
		logic [chanWidth-1:0] red;
		logic [chanWidth-1:0] green;
		logic [chanWidth-1:0] blue;
	} rgbPixel;

endpackage

`default_nettype wire
